// File: common/cfg_tag_pkg.sv
package cfg_tag_pkg;

  // ------------------------------
  // frame field widths
  // ------------------------------

  // id field of a config tag frame
  localparam int cfg_id_w_c = 8;

  // length field, counts payload bits
  localparam int cfg_len_w_c = 6;

  // largest payload a node can carry
  localparam int cfg_max_data_c = 32;

  // ------------------------------
  // channel config field widths
  // ------------------------------

  // clock divider ratio and phase select
  localparam int clk_div_ratio_w_c = 5;
  localparam int clk_phase_w_c = 3;

  // per-bit phase select width
  localparam int bit_phase_w_c = 2;

  // parsed frame, data is lsb aligned
  typedef struct packed {
    logic [cfg_id_w_c-1:0]     id;
    logic [cfg_len_w_c-1:0]    len;
    logic [cfg_max_data_c-1:0] data;
  } cfg_frame_s;

  // clock divider settings
  typedef struct packed {
    logic [clk_div_ratio_w_c-1:0] div_ratio;
    logic [clk_phase_w_c-1:0]     phase_sel;
  } clk_divider_s;

  // settings for one channel bit
  typedef struct packed {
    logic                     clk_edge_sel;
    logic [bit_phase_w_c-1:0] phase_sel;
  } bit_cfg_s;

  // channel operating mode
  typedef enum logic [1:0] {
    mode_normal = 2'b00,
    mode_sync   = 2'b01,
    mode_la     = 2'b10,
    mode_stop   = 2'b11
  } cfg_mode_e;

  // input and output side modes
  typedef struct packed {
    cfg_mode_e input_mode;
    cfg_mode_e output_mode;
  } mode_cfg_s;

endpackage

// File: cfg_tag/cfg_tag_deframer.sv
`timescale 1ns/1ps

module cfg_tag_deframer (
  input  logic                    clk,
  input  logic                    rst_n_i,
  input  logic                    cfg_data_i,
  input  logic                    cfg_valid_i,
  output logic                    frame_v_o,
  output cfg_tag_pkg::cfg_frame_s frame_o
);

  import cfg_tag_pkg::*;

  typedef enum logic [2:0] {
    st_idle,
    st_id,
    st_len,
    st_data,
    st_parity,
    st_stop
  } state_e;

  // last bit index of the fixed-width fields
  localparam logic [4:0] id_last_lp = 5'(cfg_id_w_c - 1);
  localparam logic [4:0] len_last_lp = 5'(cfg_len_w_c - 1);

  state_e                    state_r;
  logic [4:0]                bit_cnt_r;
  logic                      parity_r;
  logic [cfg_id_w_c-1:0]     id_r;
  logic [cfg_len_w_c-1:0]    len_r;
  logic [cfg_max_data_c-1:0] data_r;
  logic [cfg_len_w_c-1:0]    len_full;
  logic                      last_data_bit;

  // length as it stands once its msb arrives on the input
  assign len_full = {cfg_data_i, len_r[cfg_len_w_c-2:0]};

  assign last_data_bit = ({1'b0, bit_cnt_r} == (len_r - 6'd1));

  // ------------------------------
  // control FSM
  // ------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_r   <= st_idle;
      bit_cnt_r <= '0;
      parity_r  <= 1'b0;
      frame_v_o <= 1'b0;
    end else begin
      // frame strobe lasts a single cycle
      frame_v_o <= 1'b0;
      // cycles without valid leave everything as is
      if (cfg_valid_i) begin
        case (state_r)
          st_idle: begin
            // ones on the line are idle fill
            if (!cfg_data_i) begin
              state_r   <= st_id;
              bit_cnt_r <= '0;
              parity_r  <= 1'b0;
            end
          end
          st_id: begin
            parity_r <= parity_r ^ cfg_data_i;
            if (bit_cnt_r == id_last_lp) begin
              state_r   <= st_len;
              bit_cnt_r <= '0;
            end else begin
              bit_cnt_r <= bit_cnt_r + 5'd1;
            end
          end
          st_len: begin
            parity_r <= parity_r ^ cfg_data_i;
            if (bit_cnt_r == len_last_lp) begin
              bit_cnt_r <= '0;
              // oversized frames are dropped right here
              if (len_full > cfg_len_w_c'(cfg_max_data_c)) begin
                state_r <= st_idle;
              end else if (len_full == '0) begin
                state_r <= st_parity;
              end else begin
                state_r <= st_data;
              end
            end else begin
              bit_cnt_r <= bit_cnt_r + 5'd1;
            end
          end
          st_data: begin
            parity_r <= parity_r ^ cfg_data_i;
            if (last_data_bit) begin
              state_r <= st_parity;
            end else begin
              bit_cnt_r <= bit_cnt_r + 5'd1;
            end
          end
          st_parity: begin
            // even parity over id, len and data
            if (parity_r ^ cfg_data_i) begin
              state_r <= st_idle;
            end else begin
              state_r <= st_stop;
            end
          end
          st_stop: begin
            state_r   <= st_idle;
            frame_v_o <= cfg_data_i;
          end
          default: state_r <= st_idle;
        endcase
      end
    end
  end

  // ------------------------------
  // field shift registers
  // ------------------------------
  always_ff @(posedge clk) begin
    if (cfg_valid_i) begin
      case (state_r)
        // clear payload so short frames stay zero above len
        st_idle: if (!cfg_data_i) data_r <= '0;
        st_id:   id_r[bit_cnt_r[2:0]] <= cfg_data_i;
        st_len:  len_r[bit_cnt_r[2:0]] <= cfg_data_i;
        st_data: data_r[bit_cnt_r] <= cfg_data_i;
        default: ;
      endcase
    end
  end

  // fields hold until the next frame starts shifting
  assign frame_o = '{id: id_r, len: len_r, data: data_r};

  a_frame_v_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
    frame_v_o |=> !frame_v_o)
    else $error("frame_v_o high for two cycles");

  a_frame_len: assert property (@(posedge clk) disable iff (!rst_n_i)
    frame_v_o |-> (frame_o.len <= cfg_len_w_c'(cfg_max_data_c)))
    else $error("reported frame len above max");

endmodule

// File: cfg_tag/cfg_tag_node.sv
`timescale 1ns/1ps

module cfg_tag_node #(
  parameter logic [cfg_tag_pkg::cfg_id_w_c-1:0] id_p      = '0,
  parameter type                                payload_t = logic [7:0],
  parameter payload_t                           default_p = '0
) (
  input  logic     clk,
  input  logic     rst_n_i,
  input  logic     cfg_data_i,
  input  logic     cfg_valid_i,
  output payload_t data_o
);

  import cfg_tag_pkg::*;

  // payload width doubles as the expected frame length
  localparam int payload_w_lp = $bits(payload_t);

  logic       frame_v;
  cfg_frame_s frame;
  logic       match;

  // a node can never hold more than one frame carries
  if (payload_w_lp > cfg_max_data_c) begin : g_width_check
    $error("payload_t wider than cfg_max_data_c");
  end

  // ------------------------------
  // frame parser
  // ------------------------------
  cfg_tag_deframer deframer_i (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .cfg_data_i  (cfg_data_i),
    .cfg_valid_i (cfg_valid_i),
    .frame_v_o   (frame_v),
    .frame_o     (frame)
  );

  // id and exact length must both agree
  assign match = frame_v
               && (frame.id == id_p)
               && (frame.len == cfg_len_w_c'(payload_w_lp));

  // ------------------------------
  // config register
  // ------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      data_o <= default_p;
    end else if (match) begin
      // payload sits in the low bits of the frame data
      data_o <= payload_t'(frame.data[payload_w_lp-1:0]);
    end
  end

  // register must not move without a matching frame the cycle before
  a_load_on_match: assert property (@(posedge clk) disable iff (!rst_n_i)
    !$stable(data_o) |-> $past(match))
    else $error("node register changed without matching frame");

endmodule

// File: src/mesosync_cfg_extractor.sv
`timescale 1ns/1ps

module mesosync_cfg_extractor #(
  parameter int  ch1_width_p       = 5,
  parameter int  ch2_width_p       = 5,
  parameter int  cfg_tag_base_id_p = 10,
  localparam int width_lp          = ch1_width_p + ch2_width_p,
  localparam int sel_w_lp          = $clog2(width_lp)
) (
  input  logic                                   clk,
  input  logic                                   rst_n_i,
  input  logic                                   cfg_data_i,
  input  logic                                   cfg_valid_i,
  output cfg_tag_pkg::clk_divider_s              clk_divider_o,
  output cfg_tag_pkg::bit_cfg_s [width_lp-1:0]   bit_cfg_o,
  output cfg_tag_pkg::mode_cfg_s                 mode_cfg_o,
  output logic [sel_w_lp-1:0]                    la_input_sel_o,
  output logic [sel_w_lp-1:0]                    la_output_sel_o,
  output logic [sel_w_lp-1:0]                    v_output_sel_o,
  output logic                                   fifo_en_o,
  output logic                                   loop_back_o,
  output logic                                   channel_reset_o
);

  import cfg_tag_pkg::*;

  // divider node carries the two channel reset bits on top
  typedef struct packed {
    logic [1:0]   ch_reset;
    clk_divider_s clk_div;
  } div_payload_s;

  // cfg node payload, msb first
  typedef struct packed {
    logic                fifo_en;
    logic                loop_back;
    mode_cfg_s           mode;
    logic [sel_w_lp-1:0] la_in_sel;
    logic [sel_w_lp-1:0] la_out_sel;
    logic [sel_w_lp-1:0] v_out_sel;
  } cfg_payload_s;

  typedef bit_cfg_s [ch1_width_p-1:0] ch1_payload_t;
  typedef bit_cfg_s [ch2_width_p-1:0] ch2_payload_t;

  // stage 0 at the input, 1 feeds div/cfg, 2 feeds the bit nodes
  logic [2:0]   relay_data_r;
  logic [2:0]   relay_valid_r;
  div_payload_s div_payload;
  cfg_payload_s cfg_payload;
  logic [1:0]   ch_reset_r;

  // ------------------------------
  // relay stages
  // ------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      relay_valid_r <= '0;
    end else begin
      relay_valid_r <= {relay_valid_r[0], relay_valid_r[0], cfg_valid_i};
    end
  end

  always_ff @(posedge clk) begin
    relay_data_r <= {relay_data_r[0], relay_data_r[0], cfg_data_i};
  end

  // ------------------------------
  // tag nodes
  // ------------------------------
  cfg_tag_node #(
    .id_p      (cfg_id_w_c'(cfg_tag_base_id_p)),
    .payload_t (div_payload_s),
    .default_p ('0)
  ) divider_node_i (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .cfg_data_i  (relay_data_r[1]),
    .cfg_valid_i (relay_valid_r[1]),
    .data_o      (div_payload)
  );

  cfg_tag_node #(
    .id_p      (cfg_id_w_c'(cfg_tag_base_id_p + 1)),
    .payload_t (cfg_payload_s),
    .default_p ('0)
  ) cfg_node_i (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .cfg_data_i  (relay_data_r[1]),
    .cfg_valid_i (relay_valid_r[1]),
    .data_o      (cfg_payload)
  );

  cfg_tag_node #(
    .id_p      (cfg_id_w_c'(cfg_tag_base_id_p + 2)),
    .payload_t (ch1_payload_t),
    .default_p ('0)
  ) ch1_bit_node_i (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .cfg_data_i  (relay_data_r[2]),
    .cfg_valid_i (relay_valid_r[2]),
    .data_o      (bit_cfg_o[ch1_width_p-1:0])
  );

  cfg_tag_node #(
    .id_p      (cfg_id_w_c'(cfg_tag_base_id_p + 3)),
    .payload_t (ch2_payload_t),
    .default_p ('0)
  ) ch2_bit_node_i (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .cfg_data_i  (relay_data_r[2]),
    .cfg_valid_i (relay_valid_r[2]),
    .data_o      (bit_cfg_o[width_lp-1:ch1_width_p])
  );

  // field split
  assign clk_divider_o   = div_payload.clk_div;
  assign fifo_en_o       = cfg_payload.fifo_en;
  assign loop_back_o     = cfg_payload.loop_back;
  assign mode_cfg_o      = cfg_payload.mode;
  assign la_input_sel_o  = cfg_payload.la_in_sel;
  assign la_output_sel_o = cfg_payload.la_out_sel;
  assign v_output_sel_o  = cfg_payload.v_out_sel;

  // ------------------------------
  // channel reset
  // ------------------------------
  // released on a 01 -> 10 step, stays low while 10 is held
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      ch_reset_r      <= '0;
      channel_reset_o <= 1'b1;
    end else begin
      ch_reset_r <= div_payload.ch_reset;
      if ((div_payload.ch_reset == 2'b10)
          && ((ch_reset_r == 2'b01) || !channel_reset_o)) begin
        channel_reset_o <= 1'b0;
      end else begin
        channel_reset_o <= 1'b1;
      end
    end
  end

  // first edge out of reset must not release the channel
  a_reset_after_rst: assert property (@(posedge clk)
    $rose(rst_n_i) |=> channel_reset_o)
    else $error("channel_reset_o low right after reset");

endmodule

// File: src/mesosync_cfg_top.sv
`timescale 1ns/1ps

module mesosync_cfg_top #(
  parameter int  ch1_width_p       = 5,
  parameter int  ch2_width_p       = 5,
  parameter int  cfg_tag_base_id_p = 10,
  localparam int width_lp          = ch1_width_p + ch2_width_p,
  localparam int sel_w_lp          = $clog2(width_lp)
) (
  input  logic                                          clk,
  input  logic                                          rst_n_i,
  input  logic                                          cfg_data_i,
  input  logic                                          cfg_valid_i,
  output logic [cfg_tag_pkg::clk_div_ratio_w_c-1:0]     clk_div_ratio_o,
  output logic [cfg_tag_pkg::clk_phase_w_c-1:0]         clk_phase_sel_o,
  output logic [$bits(cfg_tag_pkg::bit_cfg_s)*width_lp-1:0] bit_cfg_o,
  output logic [1:0]                                    input_mode_o,
  output logic [1:0]                                    output_mode_o,
  output logic [sel_w_lp-1:0]                           la_input_sel_o,
  output logic [sel_w_lp-1:0]                           la_output_sel_o,
  output logic [sel_w_lp-1:0]                           v_output_sel_o,
  output logic                                          fifo_en_o,
  output logic                                          loop_back_o,
  output logic                                          channel_reset_o
);

  import cfg_tag_pkg::*;

  // struct views of the extractor outputs
  clk_divider_s            clk_div;
  bit_cfg_s [width_lp-1:0] bit_cfg;
  mode_cfg_s               mode_cfg;

  // ------------------------------
  // config extractor
  // ------------------------------
  mesosync_cfg_extractor #(
    .ch1_width_p       (ch1_width_p),
    .ch2_width_p       (ch2_width_p),
    .cfg_tag_base_id_p (cfg_tag_base_id_p)
  ) extractor_i (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .cfg_data_i      (cfg_data_i),
    .cfg_valid_i     (cfg_valid_i),
    .clk_divider_o   (clk_div),
    .bit_cfg_o       (bit_cfg),
    .mode_cfg_o      (mode_cfg),
    .la_input_sel_o  (la_input_sel_o),
    .la_output_sel_o (la_output_sel_o),
    .v_output_sel_o  (v_output_sel_o),
    .fifo_en_o       (fifo_en_o),
    .loop_back_o     (loop_back_o),
    .channel_reset_o (channel_reset_o)
  );

  // flatten to plain vectors, bit 0 config sits in the low bits
  assign clk_div_ratio_o = clk_div.div_ratio;
  assign clk_phase_sel_o = clk_div.phase_sel;
  assign bit_cfg_o       = bit_cfg;
  assign input_mode_o    = mode_cfg.input_mode;
  assign output_mode_o   = mode_cfg.output_mode;

endmodule

// File: tb/cfg_tag_driver.svh
`ifndef cfg_tag_driver_svh
`define cfg_tag_driver_svh

// ------------------------------
// serial frame driver
// ------------------------------
// included inside the testbench module, drives its cfg_data and cfg_valid
// every task starts and ends 2 ns after a rising edge

// idle cycles with valid low, data toggles at random
task automatic idle_cycles(input int unsigned n);
  for (int unsigned i = 0; i < n; i++) begin
    cfg_valid = 1'b0;
    cfg_data  = 1'($urandom);
    @(posedge clk);
    #2;
  end
endtask

// one bit, consumed on the next rising edge
task automatic drive_bit(input logic b);
  cfg_data  = b;
  cfg_valid = 1'b1;
  @(posedge clk);
  #2;
endtask

// start, id, len, data, parity, stop, all fields lsb first
task automatic send_frame(
  input logic [7:0]  id,
  input logic [5:0]  len,
  input logic [31:0] data,
  input logic        bad_parity,
  input logic        bad_stop,
  input logic        gaps
);
  bit   bits_q[$];
  logic parity;
  parity = 1'b0;
  bits_q.push_back(1'b0);
  for (int i = 0; i < 8; i++) begin
    bits_q.push_back(id[i]);
    parity = parity ^ id[i];
  end
  for (int i = 0; i < 6; i++) begin
    bits_q.push_back(len[i]);
    parity = parity ^ len[i];
  end
  for (int i = 0; i < int'(len); i++) begin
    bits_q.push_back(data[i]);
    parity = parity ^ data[i];
  end
  // even parity, flipped on request
  bits_q.push_back(parity ^ bad_parity);
  bits_q.push_back(!bad_stop);
  foreach (bits_q[i]) begin
    // up to 3 idle cycles before each bit
    if (gaps) begin
      idle_cycles($urandom_range(3, 0));
    end
    drive_bit(bits_q[i]);
  end
  cfg_valid = 1'b0;
endtask

`endif

// File: tb/tb_mesosync_cfg.sv
`timescale 1ns/1ps

module tb_mesosync_cfg;

  // node ids and payload lengths
  localparam logic [7:0] base_id_c = 8'd10;
  localparam logic [5:0] div_len_c = 6'd10;
  localparam logic [5:0] cfg_len_c = 6'd18;
  localparam logic [5:0] ch_len_c  = 6'd15;

  // 17 frames, up to 50 bits each, 4 cycles per bit with gaps
  localparam int num_frames_c      = 17;
  localparam int timeout_cycles_c  = num_frames_c * 50 * 4 + 200;

  logic        clk;
  logic        rst_n;
  logic        cfg_data;
  logic        cfg_valid;
  logic [4:0]  clk_div_ratio_o;
  logic [2:0]  clk_phase_sel_o;
  logic [29:0] bit_cfg_o;
  logic [1:0]  input_mode_o;
  logic [1:0]  output_mode_o;
  logic [3:0]  la_input_sel_o;
  logic [3:0]  la_output_sel_o;
  logic [3:0]  v_output_sel_o;
  logic        fifo_en_o;
  logic        loop_back_o;
  logic        channel_reset_o;

  // model of the node registers and the channel reset
  logic [9:0]  exp_div;
  logic [17:0] exp_cfg;
  logic [14:0] exp_ch1;
  logic [14:0] exp_ch2;
  logic        exp_cr;

  mesosync_cfg_top #(
    .ch1_width_p       (5),
    .ch2_width_p       (5),
    .cfg_tag_base_id_p (10)
  ) mesosync_cfg_top_i (
    .clk             (clk),
    .rst_n_i         (rst_n),
    .cfg_data_i      (cfg_data),
    .cfg_valid_i     (cfg_valid),
    .clk_div_ratio_o (clk_div_ratio_o),
    .clk_phase_sel_o (clk_phase_sel_o),
    .bit_cfg_o       (bit_cfg_o),
    .input_mode_o    (input_mode_o),
    .output_mode_o   (output_mode_o),
    .la_input_sel_o  (la_input_sel_o),
    .la_output_sel_o (la_output_sel_o),
    .v_output_sel_o  (v_output_sel_o),
    .fifo_en_o       (fifo_en_o),
    .loop_back_o     (loop_back_o),
    .channel_reset_o (channel_reset_o)
  );

  `include "cfg_tag_driver.svh"

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    repeat (timeout_cycles_c) @(posedge clk);
    $display("TEST FAIL");
    $fatal(1, "timeout, the directed tests did not finish in time");
  end

  // ------------------------------
  // checks and model
  // ------------------------------
  task automatic check_value(input string name, input logic [31:0] act, input logic [31:0] exp);
    if (act !== exp) begin
      $display("Error: %s actual 0x%0h expected 0x%0h", name, act, exp);
      $display("TEST FAIL");
      $fatal(1, "output mismatch");
    end
  endtask

  // div payload {ch_reset, div_ratio, phase_sel}
  // cfg payload {fifo_en, loop_back, in_mode, out_mode, la_in, la_out, v_out}
  task automatic check_all();
    check_value("clk_div_ratio_o", 32'(clk_div_ratio_o), 32'(exp_div[7:3]));
    check_value("clk_phase_sel_o", 32'(clk_phase_sel_o), 32'(exp_div[2:0]));
    check_value("bit_cfg_o", 32'(bit_cfg_o), 32'({exp_ch2, exp_ch1}));
    check_value("fifo_en_o", 32'(fifo_en_o), 32'(exp_cfg[17]));
    check_value("loop_back_o", 32'(loop_back_o), 32'(exp_cfg[16]));
    check_value("input_mode_o", 32'(input_mode_o), 32'(exp_cfg[15:14]));
    check_value("output_mode_o", 32'(output_mode_o), 32'(exp_cfg[13:12]));
    check_value("la_input_sel_o", 32'(la_input_sel_o), 32'(exp_cfg[11:8]));
    check_value("la_output_sel_o", 32'(la_output_sel_o), 32'(exp_cfg[7:4]));
    check_value("v_output_sel_o", 32'(v_output_sel_o), 32'(exp_cfg[3:0]));
    check_value("channel_reset_o", 32'(channel_reset_o), 32'(exp_cr));
  endtask

  // only exact id and length hits load a register
  task automatic model_apply(input logic [7:0] id, input logic [5:0] len, input logic [31:0] data);
    if ((id == base_id_c) && (len == div_len_c)) begin
      // release needs 10 after 01, or 10 held while already released
      exp_cr  = !((data[9:8] == 2'b10) && ((exp_div[9:8] == 2'b01) || !exp_cr));
      exp_div = data[9:0];
    end else if ((id == base_id_c + 8'd1) && (len == cfg_len_c)) begin
      exp_cfg = data[17:0];
    end else if ((id == base_id_c + 8'd2) && (len == ch_len_c)) begin
      exp_ch1 = data[14:0];
    end else if ((id == base_id_c + 8'd3) && (len == ch_len_c)) begin
      exp_ch2 = data[14:0];
    end
  endtask

  function automatic logic [31:0] rand_bits(input logic [5:0] len);
    return $urandom & ((32'h1 << len) - 32'h1);
  endfunction

  // send, update the model for good frames, then check after 5 cycles
  task automatic send_and_check(
    input logic [7:0]  id,
    input logic [5:0]  len,
    input logic [31:0] data,
    input logic        bad_parity,
    input logic        bad_stop,
    input logic        gaps
  );
    send_frame(id, len, data, bad_parity, bad_stop, gaps);
    if (!bad_parity && !bad_stop) begin
      model_apply(id, len, data);
    end
    repeat (5) @(posedge clk);
    #2;
    check_all();
  endtask

  // ------------------------------
  // directed tests
  // ------------------------------
  task automatic test_reset_values();
    @(posedge clk);
    #2;
    check_all();
  endtask

  task automatic test_payload_writes();
    send_and_check(base_id_c, div_len_c, rand_bits(div_len_c), 1'b0, 1'b0, 1'b0);
    send_and_check(base_id_c + 8'd1, cfg_len_c, rand_bits(cfg_len_c), 1'b0, 1'b0, 1'b0);
    send_and_check(base_id_c + 8'd2, ch_len_c, rand_bits(ch_len_c), 1'b0, 1'b0, 1'b0);
    send_and_check(base_id_c + 8'd3, ch_len_c, rand_bits(ch_len_c), 1'b0, 1'b0, 1'b0);
  endtask

  task automatic test_ignored_frames();
    // unknown id, then cfg id carrying a divider sized payload
    send_and_check(base_id_c + 8'd7, div_len_c, rand_bits(div_len_c), 1'b0, 1'b0, 1'b0);
    send_and_check(base_id_c + 8'd1, div_len_c, rand_bits(div_len_c), 1'b0, 1'b0, 1'b0);
  endtask

  task automatic test_corrupt_frames();
    send_and_check(base_id_c + 8'd2, ch_len_c, rand_bits(ch_len_c), 1'b1, 1'b0, 1'b0);
    send_and_check(base_id_c + 8'd3, ch_len_c, rand_bits(ch_len_c), 1'b0, 1'b1, 1'b0);
    // good frame right behind the bad ones
    send_and_check(base_id_c + 8'd2, ch_len_c, rand_bits(ch_len_c), 1'b0, 1'b0, 1'b0);
  endtask

  task automatic write_reset_bits(input logic [1:0] bits, input logic cr);
    logic [31:0] data;
    data = {22'd0, bits, 8'($urandom)};
    send_and_check(base_id_c, div_len_c, data, 1'b0, 1'b0, 1'b0);
    check_value("channel_reset_o", 32'(channel_reset_o), 32'(cr));
  endtask

  task automatic test_channel_reset();
    write_reset_bits(2'b01, 1'b1);
    write_reset_bits(2'b10, 1'b0);
    write_reset_bits(2'b10, 1'b0);
    write_reset_bits(2'b00, 1'b1);
    // 10 straight after 00 is not a release
    write_reset_bits(2'b10, 1'b1);
  endtask

  task automatic test_idle_gaps();
    logic [31:0] data;
    logic [29:0] ref_bits;
    data = rand_bits(ch_len_c);
    send_and_check(base_id_c + 8'd3, ch_len_c, data, 1'b0, 1'b0, 1'b0);
    // model state after the frame without gaps
    ref_bits = {exp_ch2, exp_ch1};
    send_and_check(base_id_c + 8'd3, ch_len_c, data ^ 32'h7fff, 1'b0, 1'b0, 1'b0);
    send_and_check(base_id_c + 8'd3, ch_len_c, data, 1'b0, 1'b0, 1'b1);
    check_value("bit_cfg_o", 32'(bit_cfg_o), 32'(ref_bits));
  endtask

  initial begin
    void'($urandom(32'h3b028071));
    rst_n     = 1'b0;
    cfg_data  = 1'b0;
    cfg_valid = 1'b0;
    exp_div   = '0;
    exp_cfg   = '0;
    exp_ch1   = '0;
    exp_ch2   = '0;
    exp_cr    = 1'b1;
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;
    test_reset_values();
    test_payload_writes();
    test_ignored_frames();
    test_corrupt_frames();
    test_channel_reset();
    test_idle_gaps();
    $display("TEST PASS");
    $finish;
  end

endmodule

// File: project.f
common/cfg_tag_pkg.sv
cfg_tag/cfg_tag_deframer.sv
cfg_tag/cfg_tag_node.sv
src/mesosync_cfg_extractor.sv
src/mesosync_cfg_top.sv
+incdir+tb
tb/tb_mesosync_cfg.sv

// File: run_sim.sh
#!/bin/sh
# compile the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f project.f \
  --top-module tb_mesosync_cfg -o sim_tb &&
./obj_dir/sim_tb || { echo "simulation failed"; exit 1; }
